//--- design/seq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared constants, register map and bus structs for the sequence recorder
// single clock domain, 8-bit samples, 256-byte sample RAM
// memory space starts right after the 16 register addresses
// ~~~~~~~~~~~~~~~~~~~~

package seq_pkg;

    // bus and memory sizes
    localparam int ABUS_W    = 16;
    localparam int MEM_BYTES = 256;
    localparam int MEM_AW    = 8;
    localparam int REG_SPACE = 16;
    localparam int REG_AW    = 4;    // index into register space

    localparam logic [7:0] VERSION = 8'd1;

    // register map
    localparam logic [REG_AW-1:0] ADDR_CTRL     = 4'd0;  // wr: soft reset, rd: version
    localparam logic [REG_AW-1:0] ADDR_START    = 4'd1;  // wr: start, rd: done in bit 0
    localparam logic [REG_AW-1:0] ADDR_EXT_EN   = 4'd2;  // bit 0 enables external start
    localparam logic [REG_AW-1:0] ADDR_COUNT_LO = 4'd3;
    localparam logic [REG_AW-1:0] ADDR_COUNT_HI = 4'd4;

    // default sample count after reset
    localparam logic [15:0] DEF_COUNT = 16'(MEM_BYTES);

    typedef logic [7:0] seq_sample_t;

    // capture counter, one bit wider than the RAM address so it can hold MEM_BYTES
    typedef logic [MEM_AW:0] cap_cnt_t;

    // one host access as seen at the top ports
    typedef struct packed {
        logic [ABUS_W-1:0] add;
        seq_sample_t       data;
        logic              rd;
        logic              wr;
    } bus_req_t;

    // one write into the sample RAM
    typedef struct packed {
        logic              en;
        logic [MEM_AW-1:0] addr;
        seq_sample_t       data;
    } mem_wr_t;

endpackage

//--- design/seq_bus_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// host address decoder and read data mux
// read data is valid the cycle after the address, steered by the previous address
// addresses past the RAM read as zero, writes there are ignored
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_bus_decode (
    input  logic                        BUS_CLK,
    input  logic                        RST,
    input  seq_pkg::bus_req_t           req,
    input  seq_pkg::seq_sample_t        reg_rdata,
    input  seq_pkg::seq_sample_t        mem_rdata,
    output seq_pkg::bus_req_t           reg_req,
    output seq_pkg::mem_wr_t            host_wr,
    output logic [seq_pkg::MEM_AW-1:0]  mem_raddr,
    output seq_pkg::seq_sample_t        rdata
);

    logic                        in_reg;
    logic                        in_mem;
    logic [seq_pkg::ABUS_W-1:0]  mem_off;
    logic [seq_pkg::ABUS_W-1:0]  prev_add;

    assign in_reg  = req.add < seq_pkg::ABUS_W'(seq_pkg::REG_SPACE);
    assign in_mem  = !in_reg &&
                     (req.add < seq_pkg::ABUS_W'(seq_pkg::REG_SPACE + seq_pkg::MEM_BYTES));
    assign mem_off = req.add - seq_pkg::ABUS_W'(seq_pkg::REG_SPACE);

    assign mem_raddr = mem_off[seq_pkg::MEM_AW-1:0];  // RAM reads every cycle

    // register side only sees strobes for its own space
    assign reg_req.add  = req.add;
    assign reg_req.data = req.data;
    assign reg_req.rd   = req.rd && in_reg;
    assign reg_req.wr   = req.wr && in_reg;

    assign host_wr.en   = req.wr && in_mem;
    assign host_wr.addr = mem_off[seq_pkg::MEM_AW-1:0];
    assign host_wr.data = req.data;

    // address of the last cycle picks the source of the read data
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            prev_add <= '0;
        end else begin
            prev_add <= req.add;
        end
    end

    always_comb begin
        if (prev_add < seq_pkg::ABUS_W'(seq_pkg::REG_SPACE)) begin
            rdata = reg_rdata;
        end else if (prev_add <
                     seq_pkg::ABUS_W'(seq_pkg::REG_SPACE + seq_pkg::MEM_BYTES)) begin
            rdata = mem_rdata;  // from the RAM output register
        end else begin
            rdata = '0;  // unmapped
        end
    end

endmodule

//--- design/seq_rec_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// recorder registers, start logic and capture counter
// count above MEM_BYTES is clamped, a new start restarts at address 0
// soft reset via ADDR_CTRL write, RAM contents are not touched
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_rec_core (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  seq_pkg::bus_req_t     reg_req,
    input  seq_pkg::seq_sample_t  seq_in,
    input  logic                  seq_ext_start,
    output seq_pkg::seq_sample_t  reg_rdata,
    output seq_pkg::mem_wr_t      cap_wr
);

    seq_pkg::seq_sample_t       regs [seq_pkg::REG_SPACE];  // written bytes
    logic [seq_pkg::REG_AW-1:0] idx;
    logic                       soft_rst;
    logic                       rst_core;
    logic                       start_sw;
    logic                       start_ext;
    logic                       start;
    logic                       ext_en;
    logic [15:0]                count_cfg;
    seq_pkg::cap_cnt_t          count_clamp;
    seq_pkg::cap_cnt_t          cap_cnt;  // next RAM address
    seq_pkg::cap_cnt_t          cap_len;  // latched sample count
    logic                       done;

    assign idx = reg_req.add[seq_pkg::REG_AW-1:0];

    assign soft_rst = reg_req.wr && (idx == seq_pkg::ADDR_CTRL);
    assign rst_core = RST || soft_rst;
    assign start_sw = reg_req.wr && (idx == seq_pkg::ADDR_START);

    assign ext_en    = regs[seq_pkg::ADDR_EXT_EN][0];
    assign count_cfg = {regs[seq_pkg::ADDR_COUNT_HI], regs[seq_pkg::ADDR_COUNT_LO]};

    // external strobe only counts while idle
    assign start_ext = ext_en && seq_ext_start && done;
    assign start     = start_sw || start_ext;

    assign count_clamp = (count_cfg > seq_pkg::DEF_COUNT) ?
                         seq_pkg::DEF_COUNT[seq_pkg::MEM_AW:0] :
                         count_cfg[seq_pkg::MEM_AW:0];

    // register file, unused addresses simply hold their byte
    always_ff @(posedge BUS_CLK) begin
        if (rst_core) begin
            for (int i = 0; i < seq_pkg::REG_SPACE; i++) begin
                regs[i] <= '0;
            end
            regs[seq_pkg::ADDR_COUNT_LO] <= seq_pkg::DEF_COUNT[7:0];
            regs[seq_pkg::ADDR_COUNT_HI] <= seq_pkg::DEF_COUNT[15:8];
        end else if (reg_req.wr) begin
            regs[idx] <= reg_req.data;
        end
    end

    // registered read data, one cycle after the address
    always_ff @(posedge BUS_CLK) begin
        if (reg_req.rd) begin
            case (idx)
                seq_pkg::ADDR_CTRL:  reg_rdata <= seq_pkg::VERSION;
                seq_pkg::ADDR_START: reg_rdata <= {7'b0, done};
                default:             reg_rdata <= regs[idx];
            endcase
        end
    end

    // capture sequencing
    // edge k: latch count, clear done
    // edges k+1..k+N: one sample per edge, done at k+N+1
    always_ff @(posedge BUS_CLK) begin
        if (rst_core) begin
            done    <= 1'b1;
            cap_cnt <= '0;
            cap_len <= seq_pkg::DEF_COUNT[seq_pkg::MEM_AW:0];
        end else if (start) begin
            done    <= 1'b0;
            cap_cnt <= '0;
            cap_len <= count_clamp;
        end else if (!done) begin
            if (cap_cnt == cap_len) begin
                done <= 1'b1;
            end else begin
                cap_cnt <= cap_cnt + 1'b1;
            end
        end
    end

    // write the sample present at the coming edge
    assign cap_wr.en   = !done && (cap_cnt < cap_len);
    assign cap_wr.addr = cap_cnt[seq_pkg::MEM_AW-1:0];
    assign cap_wr.data = seq_in;

endmodule

//--- design/seq_mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~
// RAM write port arbiter, recorder always wins
// no back-pressure, a colliding host write is lost
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_mem_arbiter (
    input  seq_pkg::mem_wr_t  cap_wr,
    input  seq_pkg::mem_wr_t  host_wr,
    output seq_pkg::mem_wr_t  ram_wr,
    output logic              host_dropped
);

    logic cap_grant;

    assign cap_grant = cap_wr.en;  // fixed priority

    always_comb begin
        if (cap_grant) begin
            ram_wr = cap_wr;
        end else begin
            ram_wr = host_wr;  // en may be 0, then nothing is written
        end
    end

    // host write lost this cycle
    assign host_dropped = cap_grant && host_wr.en;

endmodule

//--- design/seq_sample_ram.sv
// ~~~~~~~~~~~~~~~~~~~~
// simple dual-port sample RAM, one write port and one registered read port
// read during write to the same address returns the old byte
// contents start at zero and survive reset
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_sample_ram (
    input  logic                        BUS_CLK,
    input  seq_pkg::mem_wr_t            wr,
    input  logic [seq_pkg::MEM_AW-1:0]  raddr,
    output seq_pkg::seq_sample_t        rdata
);

    // zero at time zero so early reads carry no X
    seq_pkg::seq_sample_t mem [seq_pkg::MEM_BYTES] = '{default: '0};

    always_ff @(posedge BUS_CLK) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rdata <= mem[raddr];  // old data on collision
    end

endmodule

//--- design/seq_rec_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// logic-sequence recorder top on the byte-wide register bus
// everything runs on BUS_CLK, one 8-bit sample per clock
// regs at 0..15, sample RAM at 16..271
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_rec_top (
    input  logic                        BUS_CLK,
    input  logic                        RST,
    input  logic [seq_pkg::ABUS_W-1:0]  BUS_ADD,
    input  logic [7:0]                  BUS_DATA_IN,
    input  logic                        BUS_RD,
    input  logic                        BUS_WR,
    input  logic [7:0]                  SEQ_IN,
    input  logic                        SEQ_EXT_START,
    output logic [7:0]                  BUS_DATA_OUT
);

    seq_pkg::bus_req_t           bus_req;
    seq_pkg::bus_req_t           reg_req;
    seq_pkg::mem_wr_t            host_wr;
    seq_pkg::mem_wr_t            cap_wr;
    seq_pkg::mem_wr_t            ram_wr;
    seq_pkg::seq_sample_t        reg_rdata;
    seq_pkg::seq_sample_t        mem_rdata;
    logic [seq_pkg::MEM_AW-1:0]  mem_raddr;
    logic                        host_dropped;  // host write lost to a capture write

    assign bus_req = '{add: BUS_ADD, data: BUS_DATA_IN, rd: BUS_RD, wr: BUS_WR};

    seq_bus_decode i_decode (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .req       (bus_req),
        .reg_rdata (reg_rdata),
        .mem_rdata (mem_rdata),
        .reg_req   (reg_req),
        .host_wr   (host_wr),
        .mem_raddr (mem_raddr),
        .rdata     (BUS_DATA_OUT)
    );

    seq_rec_core i_core (
        .BUS_CLK       (BUS_CLK),
        .RST           (RST),
        .reg_req       (reg_req),
        .seq_in        (SEQ_IN),
        .seq_ext_start (SEQ_EXT_START),
        .reg_rdata     (reg_rdata),
        .cap_wr        (cap_wr)
    );

    seq_mem_arbiter i_arb (
        .cap_wr       (cap_wr),
        .host_wr      (host_wr),
        .ram_wr       (ram_wr),
        .host_dropped (host_dropped)
    );

    seq_sample_ram i_ram (
        .BUS_CLK (BUS_CLK),
        .wr      (ram_wr),
        .raddr   (mem_raddr),
        .rdata   (mem_rdata)
    );

endmodule

//--- testbench/seq_rec_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the recorder core, attached with bind
// every property is off while RST is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module seq_rec_asserts (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  logic               done,
    input  logic               start,
    input  seq_pkg::mem_wr_t   cap_wr,
    input  seq_pkg::cap_cnt_t  cap_len
);

    logic              started;  // first start seen since RST
    seq_pkg::cap_cnt_t wr_seen;  // capture writes since the last start

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    // counted here, apart from the core's own counter
    always_ff @(posedge BUS_CLK) begin
        if (RST || start) begin
            wr_seen <= '0;
        end else if (cap_wr.en) begin
            wr_seen <= wr_seen + 1'b1;
        end
    end

    // idle without a start stays idle, so no write follows
    no_write_when_done: assert property (@(posedge BUS_CLK) disable iff (RST)
        done && !start |=> !cap_wr.en)
        else $error("capture write while done is set");

    addr_below_count: assert property (@(posedge BUS_CLK) disable iff (RST)
        cap_wr.en |-> (wr_seen < cap_len) &&
                      (cap_wr.addr == wr_seen[seq_pkg::MEM_AW-1:0]))
        else $error("capture address reached the latched count");

    // idle until the first start
    done_until_start: assert property (@(posedge BUS_CLK) disable iff (RST)
        !started |-> done)
        else $error("done dropped before any start");

endmodule

bind seq_rec_core seq_rec_asserts u_asserts (
    .BUS_CLK (BUS_CLK),
    .RST     (RST),
    .done    (done),
    .start   (start),
    .cap_wr  (cap_wr),
    .cap_len (cap_len)
);

//--- testbench/tb_seq_rec.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for seq_rec_top, test list read from testbench/seq_rec_input.txt
// must run from the project root so that path resolves
// expected RAM is a model fed from a log of SEQ_IN per rising edge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_seq_rec;

    typedef struct packed {
        int op;
        int addr;
        int data;
        int value;
    } test_t;

    logic        BUS_CLK = 1'b0;
    logic        RST;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_RD;
    logic        BUS_WR;
    logic [7:0]  SEQ_IN;
    logic        SEQ_EXT_START;
    logic [7:0]  BUS_DATA_OUT;

    test_t       tests [$];
    logic [7:0]  model [seq_pkg::MEM_BYTES];  // expected RAM contents
    logic [7:0]  seq_log [int];               // SEQ_IN keyed by edge number
    int          edge_cnt = 0;                // rising edges so far
    int          drop_edge = 0;               // last edge with a host write lost
    int          err_cnt = 0;
    bit          load_done = 1'b0;

    seq_rec_top UUT (
        .BUS_CLK       (BUS_CLK),
        .RST           (RST),
        .BUS_ADD       (BUS_ADD),
        .BUS_DATA_IN   (BUS_DATA_IN),
        .BUS_RD        (BUS_RD),
        .BUS_WR        (BUS_WR),
        .SEQ_IN        (SEQ_IN),
        .SEQ_EXT_START (SEQ_EXT_START),
        .BUS_DATA_OUT  (BUS_DATA_OUT)
    );

    always #10 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        edge_cnt <= edge_cnt + 1;
    end

    // arbiter flag as seen just before the edge
    always @(posedge BUS_CLK) begin
        if (UUT.host_dropped) begin
            drop_edge <= edge_cnt + 1;
        end
    end

    // new random sample every falling edge, logged for the edge that samples it
    initial begin
        logic [7:0] v;
        SEQ_IN = 8'h00;
        void'($urandom(32'h6b7e_29c9));
        forever begin
            @(negedge BUS_CLK);
            v = 8'($urandom);
            SEQ_IN = v;
            seq_log[edge_cnt + 1] = v;
        end
    end

    initial begin
        int wd_cycles;
        wait (load_done);
        wd_cycles = 200 * tests.size() + 2 * seq_pkg::MEM_BYTES;
        repeat (wd_cycles) @(posedge BUS_CLK);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [15:0] reg_addr(input logic [3:0] r);
        return 16'(r);
    endfunction

    function automatic bit in_mem(input int a);
        return (a >= seq_pkg::REG_SPACE) && (a < seq_pkg::REG_SPACE + seq_pkg::MEM_BYTES);
    endfunction

    function automatic int clamp_count(input int c);
        return (c > seq_pkg::MEM_BYTES) ? seq_pkg::MEM_BYTES : c;
    endfunction

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data,
                             output int wr_edge);
        @(negedge BUS_CLK);
        BUS_ADD = addr;
        BUS_DATA_IN = data;
        BUS_WR = 1'b1;
        wr_edge = edge_cnt + 1;  // edge that takes the write
        @(negedge BUS_CLK);
        BUS_WR = 1'b0;
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [7:0] exp,
                              input string what);
        logic [7:0] got;
        @(negedge BUS_CLK);
        BUS_ADD = addr;
        BUS_RD = 1'b1;
        @(negedge BUS_CLK);
        got = BUS_DATA_OUT;  // registered, valid one cycle later
        BUS_RD = 1'b0;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, addr 0x%04h read 0x%02h, expected 0x%02h",
                     $time, what, addr, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_mem(input int addr, input int len);
        int a;
        for (int i = 0; i < len; i++) begin
            a = addr + i;
            check_read(16'(a), in_mem(a) ? model[8'(a - seq_pkg::REG_SPACE)] : 8'h00,
                       "memory contents");
        end
    endtask

    task automatic wait_done();
        logic [7:0] got;
        bit         seen;
        seen = 1'b0;
        for (int p = 0; p < seq_pkg::MEM_BYTES && !seen; p++) begin
            @(negedge BUS_CLK);
            BUS_ADD = reg_addr(seq_pkg::ADDR_START);
            BUS_RD = 1'b1;
            @(negedge BUS_CLK);
            got = BUS_DATA_OUT;
            BUS_RD = 1'b0;
            seen = got[0];
        end
        if (!seen) begin
            $display("done flag never came back after the capture started");
            err_cnt++;
        end
    endtask

    task automatic set_count(input int count);
        int unused;
        bus_write(reg_addr(seq_pkg::ADDR_COUNT_LO), 8'(count), unused);
        bus_write(reg_addr(seq_pkg::ADDR_COUNT_HI), 8'(count >> 8), unused);
    endtask

    task automatic sw_start(input int count, output int k);
        set_count(count);
        bus_write(reg_addr(seq_pkg::ADDR_START), 8'h00, k);
    endtask

    // start at edge k, sample of edge k+1+i lands at address i
    task automatic model_capture(input int k, input int n);
        for (int i = 0; i < n; i++) begin
            model[8'(i)] = seq_log[k + 1 + i];
        end
    endtask

    task automatic run_test(input test_t t);
        int k;
        int c;
        int n;
        n = clamp_count(t.value);
        case (t.op)
            1: begin  // plain bus write
                bus_write(16'(t.addr), 8'(t.data), c);
                if (in_mem(t.addr)) begin
                    model[8'(t.addr - seq_pkg::REG_SPACE)] = 8'(t.data);
                end
            end
            2: check_read(16'(t.addr), 8'(t.value), "bus read");
            3: check_mem(t.addr, t.value);
            4: begin  // software start
                sw_start(t.value, k);
                check_read(reg_addr(seq_pkg::ADDR_START), 8'h00, "done after start");
                wait_done();
                model_capture(k, n);
            end
            5: begin  // one-cycle external start pulse, data is the enable
                bus_write(reg_addr(seq_pkg::ADDR_EXT_EN), 8'(t.data), c);
                set_count(t.value);
                @(negedge BUS_CLK);
                SEQ_EXT_START = 1'b1;
                k = edge_cnt + 1;
                @(negedge BUS_CLK);
                SEQ_EXT_START = 1'b0;
                if ((t.data & 1) != 0) begin
                    check_read(reg_addr(seq_pkg::ADDR_START), 8'h00, "done after ext start");
                    wait_done();
                    model_capture(k, n);
                end else begin
                    check_read(reg_addr(seq_pkg::ADDR_START), 8'h01, "done, ext disabled");
                end
            end
            6: begin  // host write during capture is lost
                sw_start(t.value, k);
                bus_write(16'(t.addr), 8'(t.data), c);
                if (c <= k || c > k + n) begin
                    $display("host write at edge %0d fell outside the capture window", c);
                    err_cnt++;
                end else if (drop_edge != c) begin
                    $display("Mismatch at %0t: host write at edge %0d was not dropped",
                             $time, c);
                    err_cnt++;
                end
                wait_done();
                model_capture(k, n);
            end
            7: begin  // soft reset after data idle cycles
                sw_start(t.value, k);
                repeat (t.data) @(negedge BUS_CLK);
                bus_write(reg_addr(seq_pkg::ADDR_CTRL), 8'h00, c);
                model_capture(k, (c - k < n) ? c - k : n);  // abort edge still writes
                check_read(reg_addr(seq_pkg::ADDR_START), 8'h01, "done after abort");
                check_read(reg_addr(seq_pkg::ADDR_COUNT_LO), 8'(seq_pkg::MEM_BYTES),
                           "count low after abort");
                check_read(reg_addr(seq_pkg::ADDR_COUNT_HI), 8'(seq_pkg::MEM_BYTES >> 8),
                           "count high after abort");
            end
            default: begin
                $display("unknown op %0d in the input file", t.op);
                err_cnt++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    rc;
        int    op_v;
        int    addr_v;
        int    data_v;
        int    val_v;
        int    err_before;
        int    pass_cnt;
        int    fail_cnt;
        string line;
        RST = 1'b1;
        BUS_ADD = 16'h0000;
        BUS_DATA_IN = 8'h00;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        SEQ_EXT_START = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (model[i]) begin
            model[i] = 8'h00;  // RAM starts cleared
        end
        fd = $fopen("testbench/seq_rec_input.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/seq_rec_input.txt");
            fail_cnt = 1;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 1 && line[0] != 8'h23) begin  // skip '#' lines
                    rc = $sscanf(line, "%h %h %h %h", op_v, addr_v, data_v, val_v);
                    if (rc == 4) begin
                        tests.push_back(test_t'{op_v, addr_v, data_v, val_v});
                    end
                end
            end
            $fclose(fd);
            if (tests.size() == 0) begin
                $display("the input file holds no tests");
                fail_cnt = 1;
            end
        end
        load_done = 1'b1;
        repeat (2) @(negedge BUS_CLK);
        RST = 1'b0;
        foreach (tests[i]) begin
            err_before = err_cnt;
            run_test(tests[i]);
            if (err_cnt == err_before) begin
                pass_cnt++;
                $display("test %0d op %0d addr 0x%04h: ok", i, tests[i].op, tests[i].addr);
            end else begin
                fail_cnt++;
                $display("test %0d op %0d addr 0x%04h: %0d errors", i, tests[i].op,
                         tests[i].addr, err_cnt - err_before);
            end
        end
        $display("tests ok: %0d, tests with errors: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/seq_rec_input.txt
# columns, all hex: op addr data value
# op 1 write, 2 read and compare with value, 3 check value bytes of RAM from addr, 4 sw start (value = count), 5 ext start (data = enable), 6 start plus host write, 7 start aborted after data idle cycles
2 0000 00 0001
2 0001 00 0001
2 0002 00 0000
2 0003 00 0000
2 0004 00 0001
2 012c 00 0000
1 0010 a5 0000
1 0011 3c 0000
1 0020 5a 0000
1 010f c3 0000
2 0010 00 00a5
2 0011 00 003c
2 0020 00 005a
2 010f 00 00c3
1 000f 77 0000
2 000f 00 0077
3 0010 00 0020
4 0000 00 0010
3 0010 00 0020
4 0000 00 0100
3 0010 00 0100
5 0000 00 0010
3 0010 00 0010
5 0000 01 0020
3 0010 00 0030
6 0011 e7 0010
6 0015 9a 0010
3 0010 00 0010
1 0050 42 0000
7 0000 06 00c8
3 0010 00 0050
4 0000 00 012c
3 0010 00 0100
2 0003 00 002c
2 0004 00 0001

//--- tb.f
design/seq_pkg.sv
design/seq_bus_decode.sv
design/seq_rec_core.sv
design/seq_mem_arbiter.sv
design/seq_sample_ram.sv
design/seq_rec_top.sv
testbench/seq_rec_asserts.sv
testbench/tb_seq_rec.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the recorder testbench
# the log decides the result, exit status 0 only on a pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_seq_rec -f tb.f -o tb_seq_rec &&
    ./obj_dir/tb_seq_rec > sim.log 2>&1 ||
    echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null

grep -q "^TB PASSED$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 ||
    { echo "simulation failed, see sim.log"; exit 1; }
